// File: src/spi_pkg.sv
package spi_pkg;

  // frame layout, high byte is the register address
  localparam int frame_bits = 16;
  localparam int addr_bits = 8;
  localparam int data_bits = 8;

  // flops per pin before the edge detect stage
  localparam int sync_stages = 2;

  // bit counter saturates at frame_bits + 1
  // so one extra bit is enough to flag a long frame
  localparam int count_bits = $clog2(frame_bits + 2);

  // receiver states
  // rx_close lasts exactly one cycle and carries the strobe
  typedef enum logic [1:0] {
    rx_idle = 2'd0,
    rx_shift = 2'd1,
    rx_close = 2'd2
  } rx_state_t;

endpackage

// File: src/regmap_pkg.sv
package regmap_pkg;

  // register addresses as sent in the frame high byte
  typedef enum logic [spi_pkg::addr_bits-1:0] {
    addr_led = 8'd7,
    addr_mux = 8'd8,
    addr_dac = 8'd9
  } reg_addr_t;

  // routed peripheral chip selects
  localparam int num_sel = 8;

  // status leds on the board
  localparam int num_led = 2;

  // dac control lines
  // bit order ldac, rst, uni_bip_a, uni_bip_b from bit 0 upward
  localparam int dac_ctrl_bits = 4;

  // register reset values
  // empty mask means no peripheral gets the bus
  localparam logic [num_sel-1:0] mux_reset = '0;
  localparam logic [num_led-1:0] led_reset = '0;
  localparam logic [dac_ctrl_bits-1:0] dac_reset = '0;

endpackage

// File: src/spi_frame_receiver.sv
`timescale 1ns/1ps

module spi_frame_receiver (
  input  logic                          cs,
  input  logic                          reset,
  input  logic                          sclk,
  input  logic                          cs_n,
  input  logic                          mosi,
  input  logic                          special,
  output logic                          frame_valid,
  output logic                          frame_error,
  output logic [spi_pkg::addr_bits-1:0] frame_addr,
  output logic [spi_pkg::data_bits-1:0] frame_data,
  output logic                          pass_active
);

  import spi_pkg::*;

  // synchronizer chains, index 0 is closest to the pin
  logic [sync_stages-1:0] sclk_sync;
  logic [sync_stages-1:0] cs_n_sync;
  logic [sync_stages-1:0] mosi_sync;
  logic [sync_stages-1:0] special_sync;

  // edge detect stage
  logic sclk_dly;
  logic cs_n_dly;
  logic special_dly;

  // synchronized pin values seen by the fsm
  logic mosi_now;
  logic special_now;

  // edge strobes, one cycle each
  logic sclk_rise;
  logic cs_fall;
  logic cs_rise;

  rx_state_t state;
  logic [frame_bits-1:0] shift_q;
  logic [count_bits-1:0] bit_count;

  // pins are async to cs
  // idle levels on reset so no false cs edge appears
  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      sclk_sync <= '0;
      cs_n_sync <= '1;
      mosi_sync <= '0;
      special_sync <= '0;
      sclk_dly <= 1'b0;
      cs_n_dly <= 1'b1;
      special_dly <= 1'b0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[sync_stages-2:0], sclk};
      cs_n_sync <= {cs_n_sync[sync_stages-2:0], cs_n};
      mosi_sync <= {mosi_sync[sync_stages-2:0], mosi};
      special_sync <= {special_sync[sync_stages-2:0], special};
      sclk_dly <= sclk_sync[sync_stages-1];
      cs_n_dly <= cs_n_sync[sync_stages-1];
      special_dly <= special_sync[sync_stages-1];
    end
  end

  assign mosi_now = mosi_sync[sync_stages-1];
  assign special_now = special_sync[sync_stages-1];

  // mode 0 samples on the rising sclk edge
  assign sclk_rise = sclk_sync[sync_stages-1] & ~sclk_dly;
  assign cs_fall = ~cs_n_sync[sync_stages-1] & cs_n_dly;
  assign cs_rise = cs_n_sync[sync_stages-1] & ~cs_n_dly;

  // bus handed to a peripheral
  // three cycles behind the pin
  assign pass_active = ~cs_n_dly & special_dly;

  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      state <= rx_idle;
      bit_count <= '0;
    end
    else
    begin
      case (state)
        rx_idle:
        begin
          // frame only for us when special is low at cs fall
          if (cs_fall && !special_now)
          begin
            state <= rx_shift;
            bit_count <= '0;
          end
        end
        rx_shift:
        begin
          if (sclk_rise && bit_count != count_bits'(frame_bits + 1))
          begin
            bit_count <= bit_count + 1'b1;
          end
          if (cs_rise)
          begin
            state <= rx_close;
          end
        end
        rx_close:
        begin
          // a very short cs high gap can start the next frame here
          if (cs_fall && !special_now)
          begin
            state <= rx_shift;
            bit_count <= '0;
          end
          else
          begin
            state <= rx_idle;
          end
        end
        default:
        begin
          state <= rx_idle;
        end
      endcase
    end
  end

  // msb first shifter, no reset needed on payload
  always_ff @(posedge cs)
  begin
    if (state == rx_shift && sclk_rise)
    begin
      shift_q <= {shift_q[frame_bits-2:0], mosi_now};
    end
  end

  // output hold regs
  // the shifter is free for the next frame after this
  always_ff @(posedge cs)
  begin
    if (state == rx_shift && cs_rise && bit_count == count_bits'(frame_bits))
    begin
      frame_addr <= shift_q[frame_bits-1 -: addr_bits];
      frame_data <= shift_q[data_bits-1:0];
    end
  end

  // strobes live only in rx_close
  assign frame_valid = (state == rx_close) && (bit_count == count_bits'(frame_bits));
  assign frame_error = (state == rx_close) && (bit_count != count_bits'(frame_bits));

  // a frame must not be written twice
  a_valid_single: assert property (@(posedge cs) disable iff (reset)
    frame_valid |=> !frame_valid);

  a_error_single: assert property (@(posedge cs) disable iff (reset)
    frame_error |=> !frame_error);

endmodule

// File: src/reg_bank.sv
`timescale 1ns/1ps

module reg_bank (
  input  logic                                  cs,
  input  logic                                  reset,
  input  logic                                  frame_valid,
  input  logic                                  frame_error,
  input  logic [spi_pkg::addr_bits-1:0]         frame_addr,
  input  logic [spi_pkg::data_bits-1:0]         frame_data,
  input  logic                                  pass_active,
  output logic [regmap_pkg::num_sel-1:0]        sel_n,
  output logic [regmap_pkg::num_led-1:0]        led,
  output logic [regmap_pkg::dac_ctrl_bits-1:0]  dac_ctrl
);

  import regmap_pkg::*;

  // peripheral mask, bit set means that select follows the bus cs
  logic [num_sel-1:0] mux_q;

  // write only when the frame had exactly 16 bits
  logic write_en;

  assign write_en = frame_valid && !frame_error;

  // address decode
  // anything outside the map is dropped
  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      mux_q <= mux_reset;
      led <= led_reset;
      dac_ctrl <= dac_reset;
    end
    else if (write_en)
    begin
      case (frame_addr)
        addr_mux:
        begin
          mux_q <= frame_data[num_sel-1:0];
        end
        addr_led:
        begin
          // only the low bits reach the pins
          led <= frame_data[num_led-1:0];
        end
        addr_dac:
        begin
          dac_ctrl <= frame_data[dac_ctrl_bits-1:0];
        end
        default:
        begin
          mux_q <= mux_q;
        end
      endcase
    end
  end

  // routed selects
  // active low, driven only while the bus is handed over
  always_ff @(posedge cs)
  begin
    if (reset)
    begin
      sel_n <= '1;
    end
    else
    begin
      sel_n <= ~(mux_q & {num_sel{pass_active}});
    end
  end

  // receiver hands over one strobe kind per frame
  a_strobe_excl: assert property (@(posedge cs) disable iff (reset)
    !(frame_valid && frame_error));

endmodule

// File: src/spi_ctrl_top.sv
`timescale 1ns/1ps

module spi_ctrl_top (
  input  logic                           cs,
  input  logic                           reset,
  input  logic                           spi_sclk,
  input  logic                           spi_cs_n,
  input  logic                           spi_mosi,
  input  logic                           spi_special,
  output logic [regmap_pkg::num_sel-1:0] sel_n,
  output logic [regmap_pkg::num_led-1:0] led,
  output logic                           dac_ldac,
  output logic                           dac_rst,
  output logic                           dac_uni_bip_a,
  output logic                           dac_uni_bip_b
);

  import spi_pkg::*;
  import regmap_pkg::*;

  // receiver to register bank
  logic                 frame_valid;
  logic                 frame_error;
  logic [addr_bits-1:0] frame_addr;
  logic [data_bits-1:0] frame_data;
  logic                 pass_active;

  // dac register before the pin split
  logic [dac_ctrl_bits-1:0] dac_ctrl;

  spi_frame_receiver receiver_i (
    .cs          (cs),
    .reset       (reset),
    .sclk        (spi_sclk),
    .cs_n        (spi_cs_n),
    .mosi        (spi_mosi),
    .special     (spi_special),
    .frame_valid (frame_valid),
    .frame_error (frame_error),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data),
    .pass_active (pass_active)
  );

  reg_bank reg_bank_i (
    .cs          (cs),
    .reset       (reset),
    .frame_valid (frame_valid),
    .frame_error (frame_error),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data),
    .pass_active (pass_active),
    .sel_n       (sel_n),
    .led         (led),
    .dac_ctrl    (dac_ctrl)
  );

  // dac pins by bit position
  assign dac_ldac = dac_ctrl[0];
  assign dac_rst = dac_ctrl[1];
  assign dac_uni_bip_a = dac_ctrl[2];
  assign dac_uni_bip_b = dac_ctrl[3];

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real period_ns = 10.0,
  parameter int reset_cycles = 5
) (
  output logic cs,
  output logic reset
);

  // free running system clock
  initial
  begin
    cs = 1'b0;
    forever #(period_ns / 2.0) cs = ~cs;
  end

  // reset held over whole cycles, released on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge cs);
    @(negedge cs);
    reset = 1'b0;
  end

endmodule

// File: sim/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic                                 cs,
  input  logic                                 reset,
  input  logic [regmap_pkg::num_sel-1:0]       sel_n,
  input  logic [regmap_pkg::num_led-1:0]       led,
  input  logic [regmap_pkg::dac_ctrl_bits-1:0] dac_pins,
  input  logic                                 frame_sent,
  input  logic [spi_pkg::frame_bits-1:0]       frame,
  input  int                                   nbits,
  input  logic                                 special,
  input  logic                                 window_open,
  input  logic                                 check_req,
  input  int                                   test_no,
  input  logic [regmap_pkg::num_sel-1:0]       exp_sel_n,
  input  logic [regmap_pkg::num_led-1:0]       exp_led,
  input  logic [regmap_pkg::dac_ctrl_bits-1:0] exp_dac,
  input  logic                                 report_req,
  output int                                   error_count,
  output int                                   check_count
);

  import spi_pkg::*;
  import regmap_pkg::*;

  // register model built from the frame rules
  logic [num_sel-1:0]       mask_model;
  logic [num_led-1:0]       led_model;
  logic [dac_ctrl_bits-1:0] dac_model;

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t test %0d: %s", $time, test_no, msg);
    error_count++;
  endtask

  // only whole 16 bit frames with special low reach the registers
  task automatic update_model();
    if (!special && nbits == frame_bits)
    begin
      case (frame[frame_bits-1 -: addr_bits])
        addr_mux:
          mask_model = frame[num_sel-1:0];
        addr_led:
          led_model = frame[num_led-1:0];
        addr_dac:
          dac_model = frame[dac_ctrl_bits-1:0];
        default:
          ;
      endcase
    end
  endtask

  task automatic compare_outputs();
    logic [num_sel-1:0] model_sel_n;
    int errors_before;
    // selects follow the inverted mask only inside a window
    model_sel_n = window_open ? ~mask_model : '1;
    errors_before = error_count;
    check_count++;
    if (sel_n !== exp_sel_n)
      report_fail($sformatf("sel_n is %h, expected %h", sel_n, exp_sel_n));
    if (led !== exp_led)
      report_fail($sformatf("led is %h, expected %h", led, exp_led));
    if (dac_pins !== exp_dac)
      report_fail($sformatf("dac pins are %h, expected %h", dac_pins, exp_dac));
    // table rows and the model have to tell the same story
    if (model_sel_n !== exp_sel_n || led_model !== exp_led || dac_model !== exp_dac)
      report_fail("table expectation disagrees with the register model");
    if (error_count == errors_before)
      $display("test %0d ok at %0t", test_no, $time);
    else
      $display("test %0d failed with %0d mismatches", test_no, error_count - errors_before);
  endtask

  always @(posedge cs)
  begin
    if (reset)
    begin
      mask_model = mux_reset;
      led_model = led_reset;
      dac_model = dac_reset;
      error_count = 0;
      check_count = 0;
    end
    else
    begin
      if (frame_sent)
        update_model();
      if (check_req)
        compare_outputs();
      if (report_req)
        $display("checks run: %0d, errors: %0d", check_count, error_count);
    end
  end

endmodule

// File: sim/tb_spi_ctrl_top.sv
`timescale 1ns/1ps

module tb_spi_ctrl_top;

  import spi_pkg::*;
  import regmap_pkg::*;

  // one stimulus row and the outputs expected after it
  typedef struct packed {
    logic [frame_bits-1:0]    frame;
    int                       nbits;
    logic                     special;
    logic                     window;
    logic                     burst;
    logic [num_sel-1:0]       exp_sel_n;
    logic [num_led-1:0]       exp_led;
    logic [dac_ctrl_bits-1:0] exp_dac;
  } row_t;

  localparam int num_rows = 14;
  localparam int half_bit = 5;
  localparam int settle = 10;

  logic cs;
  logic reset;
  logic spi_sclk;
  logic spi_cs_n;
  logic spi_mosi;
  logic spi_special;
  logic [num_sel-1:0] sel_n;
  logic [num_led-1:0] led;
  logic dac_ldac;
  logic dac_rst;
  logic dac_uni_bip_a;
  logic dac_uni_bip_b;
  logic [dac_ctrl_bits-1:0] dac_pins;

  // checker side
  logic frame_sent;
  logic [frame_bits-1:0] sent_frame;
  int sent_bits;
  logic sent_special;
  logic window_open;
  logic check_req;
  int test_no;
  logic [num_sel-1:0] exp_sel_n;
  logic [num_led-1:0] exp_led;
  logic [dac_ctrl_bits-1:0] exp_dac;
  logic report_req;
  int error_count;
  int check_count;

  row_t rows [num_rows];
  logic [7:0] rnd [7];
  logic [num_led-1:0] led_a;
  logic [num_led-1:0] led_b;
  logic [dac_ctrl_bits-1:0] dac_a;
  logic [dac_ctrl_bits-1:0] dac_b;
  int seed;
  int checks_expected;

  // pin order ldac, rst, uni_bip_a, uni_bip_b from bit 0
  assign dac_pins = {dac_uni_bip_b, dac_uni_bip_a, dac_rst, dac_ldac};

  tb_clock_gen #(
    .period_ns    (10.0),
    .reset_cycles (5)
  ) clock_gen_i (
    .cs    (cs),
    .reset (reset)
  );

  spi_ctrl_top spi_ctrl_top_i (
    .cs            (cs),
    .reset         (reset),
    .spi_sclk      (spi_sclk),
    .spi_cs_n      (spi_cs_n),
    .spi_mosi      (spi_mosi),
    .spi_special   (spi_special),
    .sel_n         (sel_n),
    .led           (led),
    .dac_ldac      (dac_ldac),
    .dac_rst       (dac_rst),
    .dac_uni_bip_a (dac_uni_bip_a),
    .dac_uni_bip_b (dac_uni_bip_b)
  );

  tb_checker checker_i (
    .cs          (cs),
    .reset       (reset),
    .sel_n       (sel_n),
    .led         (led),
    .dac_pins    (dac_pins),
    .frame_sent  (frame_sent),
    .frame       (sent_frame),
    .nbits       (sent_bits),
    .special     (sent_special),
    .window_open (window_open),
    .check_req   (check_req),
    .test_no     (test_no),
    .exp_sel_n   (exp_sel_n),
    .exp_led     (exp_led),
    .exp_dac     (exp_dac),
    .report_req  (report_req),
    .error_count (error_count),
    .check_count (check_count)
  );

  function automatic row_t make_row(input logic [frame_bits-1:0] frame, input int nbits,
      input logic special, input logic window, input logic burst,
      input logic [num_sel-1:0] sel_exp, input logic [num_led-1:0] led_exp,
      input logic [dac_ctrl_bits-1:0] dac_exp);
    return '{frame, nbits, special, window, burst, sel_exp, led_exp, dac_exp};
  endfunction

  // mode 0, mosi changes while sclk is low
  // frame ends on the last bit sent, long frames lead with zeros
  // short frames drop their top bits
  task automatic send_frame(input row_t r, input int gap);
    spi_special = r.special;
    spi_cs_n = 1'b0;
    for (int i = 0; i < r.nbits; i++)
    begin
      spi_sclk = 1'b0;
      spi_mosi = (i < r.nbits - frame_bits) ? 1'b0 : r.frame[r.nbits-1-i];
      repeat (half_bit) @(negedge cs);
      spi_sclk = 1'b1;
      repeat (half_bit) @(negedge cs);
    end
    spi_sclk = 1'b0;
    repeat (half_bit) @(negedge cs);
    spi_cs_n = 1'b1;
    spi_special = 1'b0;
    // hand the frame to the checker model
    sent_frame = r.frame;
    sent_bits = r.nbits;
    sent_special = r.special;
    frame_sent = 1'b1;
    @(negedge cs);
    frame_sent = 1'b0;
    repeat (gap - 1) @(negedge cs);
  endtask

  task automatic run_row(input int idx);
    row_t r;
    r = rows[idx];
    // burst rows keep the cs gap at two cycles
    if (r.nbits > 0)
      send_frame(r, r.burst ? 2 : 1);
    if (!r.burst)
    begin
      repeat (settle) @(negedge cs);
      if (r.window)
      begin
        // bus handed to the routed peripherals
        spi_special = 1'b1;
        spi_cs_n = 1'b0;
        window_open = 1'b1;
        repeat (settle) @(negedge cs);
      end
      test_no = idx;
      exp_sel_n = r.exp_sel_n;
      exp_led = r.exp_led;
      exp_dac = r.exp_dac;
      check_req = 1'b1;
      @(negedge cs);
      check_req = 1'b0;
      if (r.window)
      begin
        // bus cs high with special still set releases every select
        spi_cs_n = 1'b1;
        window_open = 1'b0;
        repeat (settle) @(negedge cs);
        exp_sel_n = '1;
        check_req = 1'b1;
        @(negedge cs);
        check_req = 1'b0;
        spi_special = 1'b0;
      end
    end
  endtask

  initial
  begin
    spi_sclk = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    spi_special = 1'b0;
    frame_sent = 1'b0;
    sent_frame = '0;
    sent_bits = 0;
    sent_special = 1'b0;
    window_open = 1'b0;
    check_req = 1'b0;
    report_req = 1'b0;
    test_no = 0;
    exp_sel_n = '1;
    exp_led = '0;
    exp_dac = '0;
    seed = 32'h585c_dec3;
    for (int i = 0; i < 7; i++)
      rnd[i] = 8'($random(seed));
    // at least one select routed in each window
    rnd[3][0] = 1'b1;
    rnd[5][0] = 1'b1;
    led_a = rnd[0][num_led-1:0];
    led_b = rnd[4][num_led-1:0];
    dac_a = rnd[2][dac_ctrl_bits-1:0];
    dac_b = rnd[6][dac_ctrl_bits-1:0];
    rows[0] = make_row(16'h0000, 0, 1'b0, 1'b0, 1'b0, 8'hff, 2'b00, 4'h0);
    rows[1] = make_row({addr_led, rnd[0]}, 16, 1'b0, 1'b0, 1'b0, 8'hff, led_a, 4'h0);
    rows[2] = make_row({addr_mux, rnd[1]}, 16, 1'b0, 1'b0, 1'b0, 8'hff, led_a, 4'h0);
    rows[3] = make_row({addr_dac, rnd[2]}, 16, 1'b0, 1'b0, 1'b0, 8'hff, led_a, dac_a);
    // long, short and special frames must be ignored
    // each would land a changed value if its bit count were not checked
    // the even long frame leaves a zero on top for the short one after it
    rows[4] = make_row({addr_dac, ~rnd[2][7:1], 1'b0}, 17, 1'b0, 1'b0, 1'b0,
        8'hff, led_a, dac_a);
    rows[5] = make_row({addr_led, ~rnd[0]}, 15, 1'b0, 1'b0, 1'b0, 8'hff, led_a, dac_a);
    rows[6] = make_row({addr_led, ~rnd[0]}, 16, 1'b1, 1'b0, 1'b0, 8'hff, led_a, dac_a);
    // address 3 is outside the map
    rows[7] = make_row({8'd3, 8'hff}, 16, 1'b0, 1'b0, 1'b0, 8'hff, led_a, dac_a);
    rows[8] = make_row({addr_mux, rnd[3]}, 16, 1'b0, 1'b1, 1'b0, ~rnd[3], led_a, dac_a);
    rows[9] = make_row(16'h0000, 0, 1'b0, 1'b0, 1'b0, 8'hff, led_a, dac_a);
    // back to back burst, checked once at the end
    rows[10] = make_row({addr_led, rnd[4]}, 16, 1'b0, 1'b0, 1'b1, 8'hff, led_b, dac_a);
    rows[11] = make_row({addr_mux, rnd[5]}, 16, 1'b0, 1'b0, 1'b1, 8'hff, led_b, dac_a);
    rows[12] = make_row({addr_dac, rnd[6]}, 16, 1'b0, 1'b0, 1'b0, 8'hff, led_b, dac_b);
    rows[13] = make_row(16'h0000, 0, 1'b0, 1'b1, 1'b0, ~rnd[5], led_b, dac_b);
    checks_expected = 0;
    for (int i = 0; i < num_rows; i++)
    begin
      if (!rows[i].burst)
        checks_expected++;
      if (rows[i].window)
        checks_expected++;
    end
    @(negedge reset);
    @(negedge cs);
    for (int i = 0; i < num_rows; i++)
      run_row(i);
    report_req = 1'b1;
    @(negedge cs);
    report_req = 1'b0;
    @(negedge cs);
    if (check_count != checks_expected)
      $display("only %0d of %0d checks ran", check_count, checks_expected);
    if (error_count == 0 && check_count == checks_expected)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // watchdog, a 17 bit row plus a window stays well below 400 cycles
  initial
  begin
    repeat (num_rows * 400 + 200) @(posedge cs);
    $display("run timed out before all %0d rows finished", num_rows);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: filelist.f
src/spi_pkg.sv
src/regmap_pkg.sv
src/spi_frame_receiver.sv
src/reg_bank.sv
src/spi_ctrl_top.sv
sim/tb_clock_gen.sv
sim/tb_checker.sv
sim/tb_spi_ctrl_top.sv

// File: Makefile
# Verilator build and run for the SPI board controller

VERILATOR ?= verilator
TOP ?= tb_spi_ctrl_top
RTL_TOP ?= spi_ctrl_top
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_PATTERN ?= SIMULATION PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(shell grep '^src/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_PATTERN)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
